//--- common/alpu_pkg.sv
package alpu_pkg;

  // --------------------------------------------------------------------------
  // opcodes
  // --------------------------------------------------------------------------
  typedef enum logic [2:0] {
    op_add    = 3'd0,
    op_sub    = 3'd1,
    op_and    = 3'd2,
    op_or     = 3'd3,
    op_xor    = 3'd4,
    op_pass0  = 3'd5,  // forwards operand 0
    op_mul_lo = 3'd6   // low half of the product
  } alpu_op_e;

  // upper address bits that select the tile
  localparam int TILE_BITS = 2;

  // widest operand the evaluation supports, callers zero-extend and truncate
  localparam int MAX_DATA_WIDTH = 64;

  // --------------------------------------------------------------------------
  // evaluation
  // --------------------------------------------------------------------------
  // low bits of every result only depend on the low bits of the inputs,
  // so a narrow datapath can take the truncated result
  function automatic logic [MAX_DATA_WIDTH-1:0] alpu_eval(
    input alpu_op_e                  op,
    input logic [MAX_DATA_WIDTH-1:0] a,
    input logic [MAX_DATA_WIDTH-1:0] b
  );
    logic [MAX_DATA_WIDTH-1:0] r;
    case (op)
      op_add:    r = a + b;
      op_sub:    r = a - b;
      op_and:    r = a & b;
      op_or:     r = a | b;
      op_xor:    r = a ^ b;
      op_pass0:  r = a;
      op_mul_lo: r = a * b;  // product wraps to the word width
      default:   r = '0;     // unused encoding
    endcase
    return r;
  endfunction

endpackage

//--- operand_cache/cache_dp.sv
`timescale 1ns/100ps

module cache_dp #(
  parameter int  IDX_BITS   = 2,
  parameter int  ADDR_WIDTH = 8,
  parameter type entry_t    = logic
) (
  input  logic                  clk,
  input  logic                  reset_n,
  // port a: write, read and consume
  input  logic [ADDR_WIDTH-1:0] addra_i,
  input  logic                  cea_i,
  input  logic                  wea_i,
  input  entry_t                wdata_i,
  output entry_t                rdataa_o,
  output logic                  rhita_o,
  input  logic                  consumea_i,
  // port b: read and consume
  input  logic [ADDR_WIDTH-1:0] addrb_i,
  input  logic                  ceb_i,
  output entry_t                rdatab_o,
  output logic                  rhitb_o,
  input  logic                  consumeb_i,
  output logic                  busy_o       // port a entry holds an unread token
);
  localparam int ENTRIES  = 1 << IDX_BITS;
  localparam int TAG_BITS = ADDR_WIDTH - IDX_BITS;

  logic [TAG_BITS-1:0] tag_q  [ENTRIES];
  entry_t              data_q [ENTRIES];
  logic [ENTRIES-1:0]  tok_q;             // token-valid flags
  logic [IDX_BITS-1:0] idx_a;
  logic [IDX_BITS-1:0] idx_b;
  logic [TAG_BITS-1:0] tag_a;
  logic [TAG_BITS-1:0] tag_b;
  logic                wr;

  assign idx_a = addra_i[IDX_BITS-1:0];
  assign tag_a = addra_i[ADDR_WIDTH-1:IDX_BITS];
  assign idx_b = addrb_i[IDX_BITS-1:0];
  assign tag_b = addrb_i[ADDR_WIDTH-1:IDX_BITS];
  assign wr    = cea_i & wea_i;

  // combinational lookups, hit needs tag match and an unread token
  assign rhita_o  = cea_i & tok_q[idx_a] & (tag_q[idx_a] == tag_a);
  assign rdataa_o = data_q[idx_a];
  assign rhitb_o  = ceb_i & tok_q[idx_b] & (tag_q[idx_b] == tag_b);
  assign rdatab_o = data_q[idx_b];
  assign busy_o   = tok_q[idx_a];

  // --------------------------------------------------------------------------
  // token flags, consume clears and a write sets
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      tok_q <= '0;
    end else begin
      if (consumea_i)
        tok_q[idx_a] <= 1'b0;
      if (consumeb_i)
        tok_q[idx_b] <= 1'b0;
      if (wr)
        tok_q[idx_a] <= 1'b1;  // a write wins over a consume
    end
  end

  always_ff @(posedge clk) begin
    if (wr) begin
      tag_q[idx_a]  <= tag_a;
      data_q[idx_a] <= wdata_i;
    end
  end

  // writers must wait until the previous token at this entry was read
  assert property (@(posedge clk) disable iff (!reset_n) wr |-> !tok_q[idx_a]);

endmodule

//--- operand_cache/operand_cache.sv
`timescale 1ns/100ps

module operand_cache import alpu_pkg::*; #(
  parameter int DATA_WIDTH = 16,
  parameter int ADDR_WIDTH = 8,
  parameter int ALPU_IDX   = 0,
  parameter int IDX_BITS   = 2
) (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  head_valid_i,
  input  logic [ADDR_WIDTH-1:0] head_src0_i,
  input  logic                  head_src0_valid_i,
  input  logic [ADDR_WIDTH-1:0] head_src1_i,
  input  logic                  head_src1_valid_i,
  input  logic [DATA_WIDTH-1:0] head_imm_i,
  input  logic                  exec_ready_i,
  output logic                  issue_o,
  output logic [DATA_WIDTH-1:0] op0_data_o,
  output logic [DATA_WIDTH-1:0] op1_data_o,
  input  logic                  res_valid_i,       // local results only
  input  logic [ADDR_WIDTH-1:0] res_addr_i,
  input  logic [DATA_WIDTH-1:0] res_data_i,
  output logic                  res_ready_o,
  input  logic [DATA_WIDTH-1:0] icon_w0_data_i,
  input  logic [ADDR_WIDTH-1:0] icon_w0_addr_i,
  input  logic                  icon_w0_valid_i,
  input  logic [DATA_WIDTH-1:0] icon_w1_data_i,
  input  logic [ADDR_WIDTH-1:0] icon_w1_addr_i,
  input  logic                  icon_w1_valid_i
);
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
  } local_entry_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  src;   // interconnect bus that wrote it
  } foreign_entry_t;

  logic                       lk0, lk1;        // operand needs a store lookup
  logic                       loc0, loc1;      // operand lives on this tile
  local_entry_t               ys_q;            // staging register
  logic [ADDR_WIDTH-1:0]      ys_addr_q;
  logic                       ys_valid_q;
  logic                       bank_sel_q;      // next local bank to write
  logic                       ys_hit0, ys_hit1;
  logic [1:0]                 l_wsel, l_wr, l_rda, l_hita, l_hitb, l_busy;
  logic [1:0][ADDR_WIDTH-1:0] l_addra;
  local_entry_t [1:0]         l_rdataa, l_rdatab;
  logic [1:0]                 f_wv, f_hita, f_hitb;
  logic [1:0][ADDR_WIDTH-1:0] f_waddr, f_addra;
  logic [1:0][DATA_WIDTH-1:0] f_wdata;
  foreign_entry_t [1:0]       f_rdataa, f_rdatab;
  logic [4:0]                 hit0, hit1;      // {staging, local banks, foreign banks}
  logic                       same_tok;

  assign lk0  = head_valid_i & head_src0_valid_i;
  assign lk1  = head_valid_i & head_src1_valid_i;
  assign loc0 = head_src0_i[ADDR_WIDTH-1 -: TILE_BITS] == TILE_BITS'(ALPU_IDX);
  assign loc1 = head_src1_i[ADDR_WIDTH-1 -: TILE_BITS] == TILE_BITS'(ALPU_IDX);

  // --------------------------------------------------------------------------
  // staging register, drains into the alternating local banks
  // --------------------------------------------------------------------------
  assign ys_hit0 = lk0 & loc0 & ys_valid_q & (ys_addr_q == head_src0_i);
  assign ys_hit1 = lk1 & loc1 & ys_valid_q & (ys_addr_q == head_src1_i);
  assign l_wsel  = {ys_valid_q & bank_sel_q, ys_valid_q & ~bank_sel_q};
  assign l_wr    = l_wsel & {2{~(issue_o & (ys_hit0 | ys_hit1))}};  // hit cancels write
  assign res_ready_o = ~ys_valid_q & ~(|l_busy);

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ys_valid_q <= 1'b0;
      bank_sel_q <= 1'b0;
    end else begin
      ys_valid_q <= res_valid_i & res_ready_o;  // held for one cycle only
      if (|l_wr)
        bank_sel_q <= ~bank_sel_q;
    end
  end

  always_ff @(posedge clk) begin
    if (res_valid_i && res_ready_o) begin
      ys_q.data <= res_data_i;
      ys_addr_q <= res_addr_i;
    end
  end

  // port a writes, checks the result entry, or reads op1; port b reads op0
  assign f_wv    = {icon_w1_valid_i, icon_w0_valid_i};
  assign f_waddr = {icon_w1_addr_i, icon_w0_addr_i};
  assign f_wdata = {icon_w1_data_i, icon_w0_data_i};

  for (genvar i = 0; i < 2; i++) begin : g_bank
    assign l_rda[i]   = ~l_wsel[i] & ~res_valid_i;
    assign l_addra[i] = l_wsel[i] ? ys_addr_q : (res_valid_i ? res_addr_i : head_src1_i);
    assign f_addra[i] = f_wv[i] ? f_waddr[i] : head_src1_i;

    cache_dp #(.IDX_BITS(IDX_BITS), .ADDR_WIDTH(ADDR_WIDTH), .entry_t(local_entry_t)) l_dp (
      .clk(clk), .reset_n(reset_n),
      .addra_i(l_addra[i]), .cea_i(l_wsel[i] | res_valid_i | (lk1 & loc1)),
      .wea_i(l_wr[i]), .wdata_i(ys_q), .rdataa_o(l_rdataa[i]), .rhita_o(l_hita[i]),
      .consumea_i(issue_o & l_hita[i] & l_rda[i]),
      .addrb_i(head_src0_i), .ceb_i(lk0 & loc0), .rdatab_o(l_rdatab[i]),
      .rhitb_o(l_hitb[i]), .consumeb_i(issue_o & l_hitb[i]), .busy_o(l_busy[i])
    );

    cache_dp #(.IDX_BITS(IDX_BITS), .ADDR_WIDTH(ADDR_WIDTH), .entry_t(foreign_entry_t)) f_dp (
      .clk(clk), .reset_n(reset_n),
      .addra_i(f_addra[i]), .cea_i(f_wv[i] | (lk1 & ~loc1)),
      .wea_i(f_wv[i]), .wdata_i('{data: f_wdata[i], src: 1'(i)}),
      .rdataa_o(f_rdataa[i]), .rhita_o(f_hita[i]),
      .consumea_i(issue_o & f_hita[i] & ~f_wv[i]),
      .addrb_i(head_src0_i), .ceb_i(lk0 & ~loc0), .rdatab_o(f_rdatab[i]),
      .rhitb_o(f_hitb[i]), .consumeb_i(issue_o & f_hitb[i]), .busy_o()
    );
  end

  // --------------------------------------------------------------------------
  // operand merge and issue
  // --------------------------------------------------------------------------
  assign hit0 = {ys_hit0, l_hitb, f_hitb};
  assign hit1 = {ys_hit1, l_hita & l_rda, f_hita & ~f_wv};  // write ports can't read

  always_comb begin
    op0_data_o = head_src0_valid_i ? '0 : head_imm_i;
    op1_data_o = head_src1_valid_i ? '0 : head_imm_i;
    if (ys_hit0)
      op0_data_o |= ys_q.data;
    if (ys_hit1)
      op1_data_o |= ys_q.data;
    for (int i = 0; i < 2; i++) begin
      if (hit0[2+i]) op0_data_o |= l_rdatab[i].data;
      if (hit0[i])   op0_data_o |= f_rdatab[i].data;
      if (hit1[2+i]) op1_data_o |= l_rdataa[i].data;
      if (hit1[i])   op1_data_o |= f_rdataa[i].data;
    end
  end

  // one token can't feed both operands
  assign same_tok = head_src0_valid_i & head_src1_valid_i & (head_src0_i == head_src1_i);
  assign issue_o  = head_valid_i & (~head_src0_valid_i | (|hit0))
                  & (~head_src1_valid_i | (|hit1)) & ~same_tok & exec_ready_i;

  // a token lives in exactly one store
  assert property (@(posedge clk) disable iff (!reset_n)
    head_valid_i |-> $onehot0(hit0) && $onehot0(hit1));

endmodule

//--- source/alpu_exec.sv
`timescale 1ns/100ps

module alpu_exec import alpu_pkg::*; #(
  parameter int DATA_WIDTH = 16,
  parameter int ADDR_WIDTH = 8,
  parameter int ALPU_IDX   = 0
) (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  issue_i,
  input  alpu_op_e              op_i,
  input  logic [ADDR_WIDTH-1:0] dst_i,
  input  logic [DATA_WIDTH-1:0] op0_data_i,
  input  logic [DATA_WIDTH-1:0] op1_data_i,
  output logic                  exec_ready_o,
  // local result, back to the operand cache
  output logic                  res_valid_o,
  output logic [ADDR_WIDTH-1:0] res_addr_o,
  output logic [DATA_WIDTH-1:0] res_data_o,
  input  logic                  res_ready_i,
  // foreign result, no back-pressure
  output logic [DATA_WIDTH-1:0] icon_r0_data_o,
  output logic [ADDR_WIDTH-1:0] icon_r0_addr_o,
  output logic                  icon_r0_valid_o
);
  logic [MAX_DATA_WIDTH-1:0] eval_w;     // full-width evaluation
  logic [DATA_WIDTH-1:0]     data_q;
  logic [ADDR_WIDTH-1:0]     dst_q;
  logic                      loc_q;      // local result held
  logic                      for_q;      // foreign pulse
  logic                      dst_local;

  assign eval_w    = alpu_eval(op_i, MAX_DATA_WIDTH'(op0_data_i), MAX_DATA_WIDTH'(op1_data_i));
  assign dst_local = dst_i[ADDR_WIDTH-1 -: TILE_BITS] == TILE_BITS'(ALPU_IDX);

  // --------------------------------------------------------------------------
  // result register
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      loc_q <= 1'b0;
      for_q <= 1'b0;
    end else begin
      for_q <= issue_i & ~dst_local;  // single-cycle pulse
      if (issue_i)
        loc_q <= dst_local;
      else if (res_ready_i)
        loc_q <= 1'b0;                // cache took it
    end
  end

  always_ff @(posedge clk) begin
    if (issue_i) begin
      data_q <= eval_w[DATA_WIDTH-1:0];
      dst_q  <= dst_i;
    end
  end

  assign exec_ready_o    = ~loc_q;     // stall while a local result waits
  assign res_valid_o     = loc_q;
  assign res_addr_o      = dst_q;
  assign res_data_o      = data_q;
  assign icon_r0_valid_o = for_q;
  assign icon_r0_addr_o  = dst_q;
  assign icon_r0_data_o  = data_q;

  // a refused local result stays put until the cache takes it
  assert property (@(posedge clk) disable iff (!reset_n)
    res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_data_o) && $stable(res_addr_o));

endmodule

//--- source/alpu_tile.sv
`timescale 1ns/100ps

module alpu_tile import alpu_pkg::*; #(
  parameter int DATA_WIDTH = 16,
  parameter int ADDR_WIDTH = 8,
  parameter int ALPU_IDX   = 0,
  parameter int IQ_DEPTH   = 4,
  parameter int IDX_BITS   = 2
) (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  instr_valid_i,
  output logic                  instr_ready_o,
  input  alpu_op_e              instr_op_i,
  input  logic [ADDR_WIDTH-1:0] instr_dst_i,
  input  logic [ADDR_WIDTH-1:0] instr_src0_i,
  input  logic                  instr_src0_valid_i,
  input  logic [ADDR_WIDTH-1:0] instr_src1_i,
  input  logic                  instr_src1_valid_i,
  input  logic [DATA_WIDTH-1:0] instr_imm_i,
  input  logic [DATA_WIDTH-1:0] icon_w0_data_i,
  input  logic [ADDR_WIDTH-1:0] icon_w0_addr_i,
  input  logic                  icon_w0_valid_i,
  input  logic [DATA_WIDTH-1:0] icon_w1_data_i,
  input  logic [ADDR_WIDTH-1:0] icon_w1_addr_i,
  input  logic                  icon_w1_valid_i,
  output logic [DATA_WIDTH-1:0] icon_r0_data_o,
  output logic [ADDR_WIDTH-1:0] icon_r0_addr_o,
  output logic                  icon_r0_valid_o
);
  // head of queue
  logic                  head_valid, head_src0_valid, head_src1_valid;
  alpu_op_e              head_op;
  logic [ADDR_WIDTH-1:0] head_dst, head_src0, head_src1;
  logic [DATA_WIDTH-1:0] head_imm;
  // issue and result path
  logic                  issue, exec_ready, res_valid, res_ready;
  logic [DATA_WIDTH-1:0] op0_data, op1_data, res_data;
  logic [ADDR_WIDTH-1:0] res_addr;

  instr_queue #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH), .IQ_DEPTH(IQ_DEPTH)) iq (
    .clk, .reset_n, .instr_valid_i, .instr_ready_o, .instr_op_i, .instr_dst_i,
    .instr_src0_i, .instr_src0_valid_i, .instr_src1_i, .instr_src1_valid_i, .instr_imm_i,
    .head_valid_o(head_valid), .head_op_o(head_op), .head_dst_o(head_dst),
    .head_src0_o(head_src0), .head_src0_valid_o(head_src0_valid),
    .head_src1_o(head_src1), .head_src1_valid_o(head_src1_valid),
    .head_imm_o(head_imm), .pop_i(issue)
  );

  operand_cache #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH), .ALPU_IDX(ALPU_IDX),
                  .IDX_BITS(IDX_BITS)) oc (
    .clk, .reset_n, .head_valid_i(head_valid), .head_src0_i(head_src0),
    .head_src0_valid_i(head_src0_valid), .head_src1_i(head_src1),
    .head_src1_valid_i(head_src1_valid), .head_imm_i(head_imm), .exec_ready_i(exec_ready),
    .issue_o(issue), .op0_data_o(op0_data), .op1_data_o(op1_data),
    .res_valid_i(res_valid), .res_addr_i(res_addr), .res_data_i(res_data),
    .res_ready_o(res_ready), .icon_w0_data_i, .icon_w0_addr_i, .icon_w0_valid_i,
    .icon_w1_data_i, .icon_w1_addr_i, .icon_w1_valid_i
  );

  alpu_exec #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH), .ALPU_IDX(ALPU_IDX)) ex (
    .clk, .reset_n, .issue_i(issue), .op_i(head_op), .dst_i(head_dst),
    .op0_data_i(op0_data), .op1_data_i(op1_data), .exec_ready_o(exec_ready),
    .res_valid_o(res_valid), .res_addr_o(res_addr), .res_data_o(res_data),
    .res_ready_i(res_ready), .icon_r0_data_o, .icon_r0_addr_o, .icon_r0_valid_o
  );

endmodule

//--- source/instr_queue.sv
`timescale 1ns/100ps

module instr_queue import alpu_pkg::*; #(
  parameter int DATA_WIDTH = 16,
  parameter int ADDR_WIDTH = 8,
  parameter int IQ_DEPTH   = 4
) (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  instr_valid_i,
  output logic                  instr_ready_o,
  input  alpu_op_e              instr_op_i,
  input  logic [ADDR_WIDTH-1:0] instr_dst_i,
  input  logic [ADDR_WIDTH-1:0] instr_src0_i,
  input  logic                  instr_src0_valid_i,
  input  logic [ADDR_WIDTH-1:0] instr_src1_i,
  input  logic                  instr_src1_valid_i,
  input  logic [DATA_WIDTH-1:0] instr_imm_i,
  output logic                  head_valid_o,
  output alpu_op_e              head_op_o,
  output logic [ADDR_WIDTH-1:0] head_dst_o,
  output logic [ADDR_WIDTH-1:0] head_src0_o,
  output logic                  head_src0_valid_o,
  output logic [ADDR_WIDTH-1:0] head_src1_o,
  output logic                  head_src1_valid_o,
  output logic [DATA_WIDTH-1:0] head_imm_o,
  input  logic                  pop_i             // head issued this cycle
);
  localparam int PTR_BITS = (IQ_DEPTH > 1) ? $clog2(IQ_DEPTH) : 1;
  localparam int CNT_BITS = $clog2(IQ_DEPTH + 1);

  typedef struct packed {
    alpu_op_e              op;
    logic [ADDR_WIDTH-1:0] dst;
    logic [ADDR_WIDTH-1:0] src0;
    logic                  src0_valid;
    logic [ADDR_WIDTH-1:0] src1;
    logic                  src1_valid;
    logic [DATA_WIDTH-1:0] imm;
  } instr_t;

  instr_t              mem_q [IQ_DEPTH];  // payload, no reset
  logic [PTR_BITS-1:0] rd_ptr_q;
  logic [PTR_BITS-1:0] wr_ptr_q;
  logic [CNT_BITS-1:0] count_q;
  logic                ready_q;           // registered so it stays low in reset
  logic                push;
  logic [CNT_BITS-1:0] count_nxt;

  assign push      = instr_valid_i & ready_q;
  assign count_nxt = count_q + CNT_BITS'(push) - CNT_BITS'(pop_i);

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
      ready_q  <= 1'b0;
    end else begin
      if (push)
        wr_ptr_q <= (wr_ptr_q == PTR_BITS'(IQ_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop_i)
        rd_ptr_q <= (rd_ptr_q == PTR_BITS'(IQ_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      count_q <= count_nxt;
      ready_q <= count_nxt != CNT_BITS'(IQ_DEPTH);  // room for one more
    end
  end

  always_ff @(posedge clk) begin
    if (push)
      mem_q[wr_ptr_q] <= '{instr_op_i, instr_dst_i, instr_src0_i, instr_src0_valid_i,
                           instr_src1_i, instr_src1_valid_i, instr_imm_i};
  end

  assign instr_ready_o     = ready_q;
  assign head_valid_o      = count_q != '0;
  assign head_op_o         = mem_q[rd_ptr_q].op;
  assign head_dst_o        = mem_q[rd_ptr_q].dst;
  assign head_src0_o       = mem_q[rd_ptr_q].src0;
  assign head_src0_valid_o = mem_q[rd_ptr_q].src0_valid;
  assign head_src1_o       = mem_q[rd_ptr_q].src1;
  assign head_src1_valid_o = mem_q[rd_ptr_q].src1_valid;
  assign head_imm_o        = mem_q[rd_ptr_q].imm;

  // the cache only issues a head that exists
  assert property (@(posedge clk) disable iff (!reset_n) pop_i |-> count_q != '0);

endmodule

//--- test/alpu_ref.svh
`ifndef ALPU_REF_SVH
`define ALPU_REF_SVH

  // --------------------------------------------------------------------------
  // reference model inside the testbench module
  // --------------------------------------------------------------------------
  logic [DATA_WIDTH-1:0] tok_data [1 << ADDR_WIDTH];      // unread tokens by address
  bit                    tok_here [1 << ADDR_WIDTH];      // token waiting at this address
  logic [ADDR_WIDTH-1:0] exp_addr_q [$];                   // expected icon_r0 traffic
  logic [DATA_WIDTH-1:0] exp_data_q [$];
  int                    exp_total = 0;                    // outputs predicted so far

  // opcode rules with the product kept to the low word
  function automatic logic [DATA_WIDTH-1:0] expected_result(
    input alpu_op_e op, input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b);
    logic [2*DATA_WIDTH-1:0] prod;
    prod = a * b;
    case (op)
      op_add:    return a + b;
      op_sub:    return a - b;
      op_and:    return a & b;
      op_or:     return a | b;
      op_xor:    return a ^ b;
      op_pass0:  return a;
      op_mul_lo: return prod[DATA_WIDTH-1:0];
      default:   return '0;
    endcase
  endfunction

  task automatic put_token(input logic [ADDR_WIDTH-1:0] addr,
                           input logic [DATA_WIDTH-1:0] data);
    tok_data[addr] = data;
    tok_here[addr] = 1'b1;
  endtask

  // immediate when the address is marked invalid, otherwise the token is used up
  function automatic logic [DATA_WIDTH-1:0] resolve_operand(
    input logic valid, input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] imm);
    logic [DATA_WIDTH-1:0] v;
    if (!valid)
      return imm;
    if (!tok_here[addr]) begin
      $display("no token at address 0x%h for an operand", addr);  // stimulus bug
      errors++;
      return '0;
    end
    v = tok_data[addr];
    tok_here[addr] = 1'b0;
    return v;
  endfunction

  task automatic predict_instr(input alpu_op_e op, input logic [ADDR_WIDTH-1:0] dst,
                               input logic [ADDR_WIDTH-1:0] s0, input logic s0v,
                               input logic [ADDR_WIDTH-1:0] s1, input logic s1v,
                               input logic [DATA_WIDTH-1:0] imm);
    logic [DATA_WIDTH-1:0] res;
    res = expected_result(op, resolve_operand(s0v, s0, imm), resolve_operand(s1v, s1, imm));
    if (dst[ADDR_WIDTH-1 -: TILE_BITS] == TILE_BITS'(ALPU_IDX)) begin
      put_token(dst, res);  // stays on the tile
    end else begin
      exp_addr_q.push_back(dst);
      exp_data_q.push_back(res);
      exp_total++;
    end
  endtask

`endif

//--- test/tb_alpu_tile.sv
`timescale 1ns/100ps

module tb_alpu_tile import alpu_pkg::*; ();
  localparam int DATA_WIDTH = 16;
  localparam int ADDR_WIDTH = 8;
  localparam int ALPU_IDX   = 0;
  localparam int TIMEOUT    = 500;  // cycles allowed per wait

  logic                  clk, reset_n;
  logic                  instr_valid_i, instr_ready_o;
  alpu_op_e              instr_op_i;
  logic [ADDR_WIDTH-1:0] instr_dst_i, instr_src0_i, instr_src1_i;
  logic                  instr_src0_valid_i, instr_src1_valid_i;
  logic [DATA_WIDTH-1:0] instr_imm_i, icon_w0_data_i, icon_w1_data_i, icon_r0_data_o;
  logic [ADDR_WIDTH-1:0] icon_w0_addr_i, icon_w1_addr_i, icon_r0_addr_o;
  logic                  icon_w0_valid_i, icon_w1_valid_i, icon_r0_valid_o;
  int                    tests = 0;
  int                    checks = 0;
  int                    errors = 0;
  int                    rcv_count = 0;  // icon_r0 outputs seen
  logic                  timed_out = 1'b0;

  `include "alpu_ref.svh"

  alpu_tile #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH), .ALPU_IDX(ALPU_IDX),
              .IQ_DEPTH(4), .IDX_BITS(2)) alpu_tile_inst (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // compare process, registered outputs still show the last cycle at the edge
  // --------------------------------------------------------------------------
  task automatic check_data(input logic [DATA_WIDTH-1:0] got, input logic [DATA_WIDTH-1:0] exp);
    checks++;
    if (got !== exp) begin
      $display("FAILED icon_r0_data_o got 0x%h expected 0x%h", got, exp);
      errors++;
    end
  endtask

  task automatic check_addr(input logic [ADDR_WIDTH-1:0] got, input logic [ADDR_WIDTH-1:0] exp);
    checks++;
    if (got !== exp) begin
      $display("FAILED icon_r0_addr_o got 0x%h expected 0x%h", got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("FAILED %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  always @(posedge clk) begin
    if (reset_n && icon_r0_valid_o) begin
      if (exp_addr_q.size() == 0) begin
        $display("output to 0x%h appeared with nothing expected", icon_r0_addr_o);
        errors++;
      end else begin
        check_addr(icon_r0_addr_o, exp_addr_q.pop_front());
        check_data(icon_r0_data_o, exp_data_q.pop_front());
      end
      rcv_count++;
    end
  end

  initial begin
    wait (timed_out);
    $display("STATUS: FAIL");
    $finish;
  end

  // --------------------------------------------------------------------------
  // drivers and waits run on the falling edge
  // --------------------------------------------------------------------------
  task automatic abort_on_timeout(input string why);
    $display("timeout: %s", why);
    timed_out = 1'b1;
    forever @(negedge clk);
  endtask

  task automatic send_instr(input alpu_op_e op, input logic [ADDR_WIDTH-1:0] dst,
                            input logic [ADDR_WIDTH-1:0] s0, input logic s0v,
                            input logic [ADDR_WIDTH-1:0] s1, input logic s1v,
                            input logic [DATA_WIDTH-1:0] imm);
    int n;
    n = 0;
    instr_op_i         = op;
    instr_dst_i        = dst;
    instr_src0_i       = s0;
    instr_src0_valid_i = s0v;
    instr_src1_i       = s1;
    instr_src1_valid_i = s1v;
    instr_imm_i        = imm;
    instr_valid_i      = 1'b1;
    while (!instr_ready_o && n < TIMEOUT) begin  // ready only moves on the rising edge
      @(negedge clk);
      n++;
    end
    if (!instr_ready_o) begin
      abort_on_timeout("instruction never accepted");
    end else begin
      @(negedge clk);  // transfer on the edge just passed
      instr_valid_i = 1'b0;
      predict_instr(op, dst, s0, s0v, s1, s1v, imm);
    end
  endtask

  task automatic drive_icon_write(input int bus, input logic [ADDR_WIDTH-1:0] addr,
                                  input logic [DATA_WIDTH-1:0] data);
    if (bus == 0) begin
      icon_w0_addr_i  = addr;
      icon_w0_data_i  = data;
      icon_w0_valid_i = 1'b1;
    end else begin
      icon_w1_addr_i  = addr;
      icon_w1_data_i  = data;
      icon_w1_valid_i = 1'b1;
    end
    @(negedge clk);    // one token per cycle
    icon_w0_valid_i = 1'b0;
    icon_w1_valid_i = 1'b0;
  endtask

  task automatic wait_outputs(input int target, input string what);
    int n;
    n = 0;
    while (rcv_count < target && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (rcv_count < target)
      abort_on_timeout({"missing outputs in ", what});
    else
      repeat (4) @(negedge clk);  // room for a duplicate to show up
  endtask

  task automatic report_test(input string name, input int err_at_start);
    tests++;
    $display("test %0d %s: %s, %0d outputs so far", tests, name,
             (errors == err_at_start) ? "ok" : "errors", rcv_count);
  endtask

  function automatic logic [ADDR_WIDTH-1:0] random_foreign_addr();
    logic [TILE_BITS-1:0] tile;
    tile = TILE_BITS'(ALPU_IDX + $urandom_range(1, (1 << TILE_BITS) - 1));  // never ours
    return {tile, (ADDR_WIDTH-TILE_BITS)'($urandom)};
  endfunction

  // --------------------------------------------------------------------------
  // tests
  // --------------------------------------------------------------------------
  initial begin
    int                    e;
    int                    base;
    int                    sel;
    logic [DATA_WIDTH-1:0] d0, d1, d2;
    logic [ADDR_WIDTH-1:0] loc;
    void'($urandom(32'h9c0f));
    reset_n            = 1'b0;
    instr_valid_i      = 1'b0;
    instr_op_i         = op_add;
    instr_dst_i        = '0;
    instr_src0_i       = '0;
    instr_src0_valid_i = 1'b0;
    instr_src1_i       = '0;
    instr_src1_valid_i = 1'b0;
    instr_imm_i        = '0;
    icon_w0_data_i     = '0;
    icon_w0_addr_i     = '0;
    icon_w0_valid_i    = 1'b0;
    icon_w1_data_i     = '0;
    icon_w1_addr_i     = '0;
    icon_w1_valid_i    = 1'b0;
    repeat (5) @(negedge clk);

    e = errors;  // nothing accepted and nothing sent while in reset
    check_flag("instr_ready_o", instr_ready_o, 1'b0);
    check_flag("icon_r0_valid_o", icon_r0_valid_o, 1'b0);
    reset_n = 1'b1;
    @(negedge clk);  // ready rises on the first cycle after reset
    check_flag("instr_ready_o", instr_ready_o, 1'b1);
    report_test("reset values", e);

    e = errors;  // every opcode on immediates sent to another tile
    for (int r = 0; r < 2; r++)
      for (int i = 0; i <= 6; i++)
        send_instr(alpu_op_e'(i), 8'h80 | ADDR_WIDTH'(8*r + i), '0, 1'b0, '0, 1'b0,
                   DATA_WIDTH'($urandom));
    wait_outputs(exp_total, "immediate opcodes");
    report_test("immediate opcodes", e);

    e = errors;  // foreign tokens first, then tokens after the instruction
    d0 = DATA_WIDTH'($urandom);
    d1 = DATA_WIDTH'($urandom);
    put_token(8'h41, d0);
    put_token(8'h46, d1);
    drive_icon_write(0, 8'h41, d0);
    drive_icon_write(1, 8'h46, d1);
    send_instr(op_sub, 8'hC4, 8'h41, 1'b1, 8'h46, 1'b1, '0);
    wait_outputs(exp_total, "tokens before");
    d0 = DATA_WIDTH'($urandom);
    d1 = DATA_WIDTH'($urandom);
    d2 = DATA_WIDTH'($urandom);
    put_token(8'h7A, d0);
    put_token(8'h95, d1);
    put_token(8'h5F, d2);
    send_instr(op_mul_lo, 8'hC5, 8'h95, 1'b1, 8'h7A, 1'b1, '0);
    send_instr(op_and, 8'hE0, 8'h5F, 1'b1, '0, 1'b0, DATA_WIDTH'($urandom));
    repeat (6) @(negedge clk);
    drive_icon_write(0, 8'h7A, d0);
    repeat (3) @(negedge clk);
    drive_icon_write(1, 8'h95, d1);
    drive_icon_write(1, 8'h5F, d2);
    wait_outputs(exp_total, "tokens after");
    report_test("foreign operands", e);

    e = errors;  // back-to-back chains go through the staging register
    send_instr(op_add, 8'h05, '0, 1'b0, '0, 1'b0, DATA_WIDTH'($urandom));
    send_instr(op_xor, 8'hC8, 8'h05, 1'b1, '0, 1'b0, DATA_WIDTH'($urandom));
    send_instr(op_or, 8'h12, '0, 1'b0, '0, 1'b0, DATA_WIDTH'($urandom));
    send_instr(op_sub, 8'h13, 8'h12, 1'b1, '0, 1'b0, DATA_WIDTH'($urandom));
    send_instr(op_add, 8'hC9, '0, 1'b0, 8'h13, 1'b1, DATA_WIDTH'($urandom));
    wait_outputs(exp_total, "local back-to-back");
    send_instr(op_pass0, 8'h06, '0, 1'b0, '0, 1'b0, DATA_WIDTH'($urandom));  // lands in one bank
    repeat (8) @(negedge clk);
    send_instr(op_mul_lo, 8'h0B, '0, 1'b0, '0, 1'b0, DATA_WIDTH'($urandom));  // and the other
    repeat (8) @(negedge clk);
    send_instr(op_sub, 8'hCA, 8'h06, 1'b1, 8'h0B, 1'b1, '0);
    wait_outputs(exp_total, "local spaced");
    report_test("local chains", e);

    e = errors;  // second reader waits for a fresh token
    base = rcv_count;
    d0 = DATA_WIDTH'($urandom);
    d1 = DATA_WIDTH'($urandom);
    put_token(8'h52, d0);
    drive_icon_write(0, 8'h52, d0);
    send_instr(op_add, 8'hD0, 8'h52, 1'b1, '0, 1'b0, DATA_WIDTH'($urandom));
    put_token(8'h52, d1);
    send_instr(op_or, 8'hD1, '0, 1'b0, 8'h52, 1'b1, DATA_WIDTH'($urandom));
    send_instr(op_xor, 8'hD2, '0, 1'b0, '0, 1'b0, DATA_WIDTH'($urandom));  // stuck behind it
    wait_outputs(base + 1, "first reader");
    repeat (10) @(negedge clk);
    if (rcv_count != base + 1) begin
      $display("instruction issued on a token that was already consumed");
      errors++;
    end
    drive_icon_write(1, 8'h52, d1);
    wait_outputs(exp_total, "second reader");
    report_test("consume once", e);

    e = errors;  // bursts with local producers stalling the execution register
    for (int b = 0; b < 3; b++) begin
      for (int i = 0; i < 20; i++) begin
        if ($urandom_range(0, 2) == 0) begin
          loc = {TILE_BITS'(ALPU_IDX), (ADDR_WIDTH-TILE_BITS)'($urandom)};
          sel = $urandom_range(0, 1);
          send_instr(alpu_op_e'($urandom_range(0, 6)), loc, '0, 1'b0, '0, 1'b0,
                     DATA_WIDTH'($urandom));
          send_instr(alpu_op_e'($urandom_range(0, 6)), random_foreign_addr(),
                     loc, sel == 0, loc, sel == 1, DATA_WIDTH'($urandom));
        end else begin
          send_instr(alpu_op_e'($urandom_range(0, 6)), random_foreign_addr(),
                     '0, 1'b0, '0, 1'b0, DATA_WIDTH'($urandom));
        end
        repeat ($urandom_range(0, 2)) @(negedge clk);
      end
      wait_outputs(exp_total, "random burst");
    end
    report_test("random bursts", e);

    $display("tests %0d, checks %0d, outputs %0d of %0d, errors %0d",
             tests, checks, rcv_count, exp_total, errors);
    if (errors == 0 && rcv_count == exp_total)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+test
common/alpu_pkg.sv
operand_cache/cache_dp.sv
operand_cache/operand_cache.sv
source/instr_queue.sv
source/alpu_exec.sv
source/alpu_tile.sv
test/tb_alpu_tile.sv
